// File: build.f
+incdir+verif
common/fc_pkg.sv
weights/fc_weight_store.sv
hdl/fc_step_ctrl.sv
mac/fc_lane_sum.sv
mac/fc_accum.sv
hdl/fc_top.sv
verif/tb_fc.sv

// File: common/fc_pkg.sv
package fc_pkg;

	// lane, beat sum and result width
	localparam int DATA_W = 32;

	typedef logic signed [DATA_W-1:0] data_t;

	// default layer shape
	localparam int DEF_LANES   = 6;   // parallel lanes per beat
	localparam int DEF_STEPS   = 16;  // beats per output neuron
	localparam int DEF_NEURONS = 2;

	// weight store fill state
	typedef enum logic
	{
		w_loading,
		w_ready
	} weight_state_e;

endpackage

// File: hdl/fc_step_ctrl.sv
`timescale 1ns/1ps

module fc_step_ctrl import fc_pkg::*; #(
	parameter int STEPS   = DEF_STEPS,
	parameter int NEURONS = DEF_NEURONS,
	localparam int STEP_W = (STEPS > 1) ? $clog2(STEPS) : 1,
	localparam int NEU_W  = (NEURONS > 1) ? $clog2(NEURONS) : 1
) (
	input  logic              clk,
	input  logic              rstn,
	input  logic              in_valid,
	input  logic              ready,
	output logic [STEP_W-1:0] step_idx,
	output logic [NEU_W-1:0]  neuron_idx,
	output logic              beat_valid,
	output logic              beat_last,
	output logic [NEU_W-1:0]  beat_neuron
);

	logic neuron_wrap;

	// beats before the store is full are dropped here
	assign beat_valid  = in_valid && ready;
	assign beat_last   = (step_idx == STEP_W'(STEPS - 1));
	assign beat_neuron = neuron_idx;
	assign neuron_wrap = (neuron_idx == NEU_W'(NEURONS - 1));

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			step_idx   <= '0;
			neuron_idx <= '0;
		end
		else if (beat_valid)
		begin
			if (beat_last)
			begin
				step_idx <= '0;
				// group done, move to next neuron
				if (neuron_wrap)
					neuron_idx <= '0;
				else
					neuron_idx <= neuron_idx + 1'b1;
			end
			else
			begin
				step_idx <= step_idx + 1'b1;
			end
		end
	end

endmodule

// File: hdl/fc_top.sv
`timescale 1ns/1ps

module fc_top import fc_pkg::*; #(
	parameter int LANES   = DEF_LANES,
	parameter int STEPS   = DEF_STEPS,
	parameter int NEURONS = DEF_NEURONS,
	localparam int STEP_W = (STEPS > 1) ? $clog2(STEPS) : 1,
	localparam int NEU_W  = (NEURONS > 1) ? $clog2(NEURONS) : 1
) (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    weight,
	input  logic                    weight_en,
	input  logic                    in_valid,
	input  logic [LANES*DATA_W-1:0] din,   // lane 0 in the low word
	output logic                    out_valid,
	output data_t                   dout,
	output logic [NEU_W-1:0]        out_neuron,
	output logic                    ready
);

	logic [STEP_W-1:0] step_idx;
	logic [NEU_W-1:0]  neuron_idx;
	logic [LANES-1:0]  lane_w;
	logic              beat_valid;
	logic              beat_last;
	logic [NEU_W-1:0]  beat_neuron;
	logic              sum_valid;
	logic              sum_last;
	logic [NEU_W-1:0]  sum_neuron;
	data_t             sum;

	fc_weight_store #(
		.LANES   (LANES),
		.STEPS   (STEPS),
		.NEURONS (NEURONS)
	) u_store (
		.clk        (clk),
		.rstn       (rstn),
		.weight     (weight),
		.weight_en  (weight_en),
		.step_idx   (step_idx),
		.neuron_idx (neuron_idx),
		.ready      (ready),
		.lane_w     (lane_w)
	);

	fc_step_ctrl #(
		.STEPS   (STEPS),
		.NEURONS (NEURONS)
	) u_ctrl (
		.clk         (clk),
		.rstn        (rstn),
		.in_valid    (in_valid),
		.ready       (ready),
		.step_idx    (step_idx),
		.neuron_idx  (neuron_idx),
		.beat_valid  (beat_valid),
		.beat_last   (beat_last),
		.beat_neuron (beat_neuron)
	);

	// weights for the current beat come back combinationally
	fc_lane_sum #(
		.LANES   (LANES),
		.NEURONS (NEURONS)
	) u_sum (
		.clk         (clk),
		.rstn        (rstn),
		.beat_valid  (beat_valid),
		.beat_last   (beat_last),
		.beat_neuron (beat_neuron),
		.din         (din),
		.lane_w      (lane_w),
		.sum_valid   (sum_valid),
		.sum_last    (sum_last),
		.sum_neuron  (sum_neuron),
		.sum         (sum)
	);

	fc_accum #(
		.NEURONS (NEURONS)
	) u_acc (
		.clk        (clk),
		.rstn       (rstn),
		.sum_valid  (sum_valid),
		.sum_last   (sum_last),
		.sum_neuron (sum_neuron),
		.sum        (sum),
		.out_valid  (out_valid),
		.dout       (dout),
		.out_neuron (out_neuron)
	);

endmodule

// File: mac/fc_accum.sv
`timescale 1ns/1ps

module fc_accum import fc_pkg::*; #(
	parameter int NEURONS = DEF_NEURONS,
	localparam int NEU_W  = (NEURONS > 1) ? $clog2(NEURONS) : 1
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic             sum_valid,
	input  logic             sum_last,
	input  logic [NEU_W-1:0] sum_neuron,
	input  data_t            sum,
	output logic             out_valid,
	output data_t            dout,
	output logic [NEU_W-1:0] out_neuron
);

	data_t acc;
	data_t acc_next;
	logic  finish;

	assign acc_next = acc + sum;   // wraps mod 2^32
	assign finish   = sum_valid && sum_last;

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			acc       <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= finish;
			if (finish)
				acc <= '0;   // next group starts clean
			else if (sum_valid)
				acc <= acc_next;
		end
	end

	// result includes the last beat's sum
	always_ff @(posedge clk)
	begin
		if (finish)
		begin
			dout       <= acc_next;
			out_neuron <= sum_neuron;
		end
	end

endmodule

// File: mac/fc_lane_sum.sv
`timescale 1ns/1ps

module fc_lane_sum import fc_pkg::*; #(
	parameter int LANES   = DEF_LANES,
	parameter int NEURONS = DEF_NEURONS,
	localparam int NEU_W  = (NEURONS > 1) ? $clog2(NEURONS) : 1,
	localparam int DEPTH  = 4   // sign stage plus three tree levels
) (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    beat_valid,
	input  logic                    beat_last,
	input  logic [NEU_W-1:0]        beat_neuron,
	input  logic [LANES*DATA_W-1:0] din,
	input  logic [LANES-1:0]        lane_w,
	output logic                    sum_valid,
	output logic                    sum_last,
	output logic [NEU_W-1:0]        sum_neuron,
	output data_t                   sum
);

	// node count at a given tree level
	function automatic int level_size(int lvl);
		int n;
		n = LANES;
		for (int k = 0; k < lvl; k++)
			n = (n + 1) / 2;
		return n;
	endfunction

	// level 0 holds the sign-selected lanes
	data_t            tree [DEPTH][LANES];
	logic [DEPTH-1:0] valid_sr;
	logic [DEPTH-1:0] last_sr;
	logic [NEU_W-1:0] neuron_sr [DEPTH];

	// weight 1 passes the lane, weight 0 negates it
	always_ff @(posedge clk)
	begin
		for (int l = 0; l < LANES; l++)
			tree[0][l] <= lane_w[l] ? data_t'(din[l*DATA_W +: DATA_W])
				: -data_t'(din[l*DATA_W +: DATA_W]);
	end

	// pairwise adds, odd leftover node is carried one level
	for (genvar lv = 1; lv < DEPTH; lv++)
	begin : g_lvl
		for (genvar i = 0; i < level_size(lv); i++)
		begin : g_node
			if (2 * i + 1 < level_size(lv - 1))
			begin : g_add
				always_ff @(posedge clk)
				begin
					tree[lv][i] <= tree[lv-1][2*i] + tree[lv-1][2*i+1];
				end
			end
			else
			begin : g_pass
				always_ff @(posedge clk)
				begin
					tree[lv][i] <= tree[lv-1][2*i];
				end
			end
		end
	end

	// tags follow the data through the same number of stages
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[DEPTH-2:0], beat_valid};
	end

	always_ff @(posedge clk)
	begin
		last_sr      <= {last_sr[DEPTH-2:0], beat_last};
		neuron_sr[0] <= beat_neuron;
		for (int k = 1; k < DEPTH; k++)
			neuron_sr[k] <= neuron_sr[k-1];
	end

	assign sum_valid  = valid_sr[DEPTH-1];
	assign sum_last   = last_sr[DEPTH-1];
	assign sum_neuron = neuron_sr[DEPTH-1];
	assign sum        = tree[DEPTH-1][0];   // single node for up to 8 lanes

endmodule

// File: verif/tb_fc_util.svh
`ifndef TB_FC_UTIL_SVH
`define TB_FC_UTIL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		r    = {r[30:0], fb};
	end
	return r;
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		err_count++;
		$display("error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
	end
endtask

// neuron block, then lane, then step
function automatic int weight_index(input int neu, input int lane, input int stp);
	return neu * LANES * STEPS + lane * STEPS + stp;
endfunction

// weight 1 keeps the lane, weight 0 takes its two's complement
function automatic logic [31:0] lane_term(input logic w, input logic [31:0] x);
	if (w)
		return x;
	else
		return ~x + 32'd1;
endfunction

// one beat's contribution, wrapped to 32 bits
function automatic logic [31:0] beat_total(input logic [LANES*DATA_W-1:0] beat,
	input int neu, input int stp);
	logic [31:0] t;
	logic [31:0] x;
	t = '0;
	for (int l = 0; l < LANES; l++)
	begin
		x = beat[l*DATA_W +: DATA_W];
		t = t + lane_term(model_w[weight_index(neu, l, stp)], x);
	end
	return t;
endfunction

`endif

// File: verif/tb_fc.sv
`timescale 1ns/1ps

module tb_fc import fc_pkg::*;;

	localparam int LANES   = DEF_LANES;
	localparam int STEPS   = DEF_STEPS;
	localparam int NEURONS = DEF_NEURONS;
	localparam int TOTAL   = LANES * STEPS * NEURONS;
	localparam int LATENCY = 5;   // accept edge to the edge that sees out_valid
	localparam int NEU_W   = (NEURONS > 1) ? $clog2(NEURONS) : 1;

	logic                    clk = 1'b0;
	logic                    rstn;
	logic                    weight;
	logic                    weight_en;
	logic                    in_valid;
	logic [LANES*DATA_W-1:0] din;
	logic                    out_valid;
	data_t                   dout;
	logic [NEU_W-1:0]        out_neuron;
	logic                    ready;

	logic [15:0] lfsr = 16'd49257;
	int          err_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	// model state
	logic        model_w [TOTAL];
	int          wcount;
	bit          m_ready;
	int          m_step;
	int          m_neuron;
	logic [31:0] m_acc;
	longint      cycle = 0;
	logic [31:0] exp_dout [$];
	int          exp_neuron [$];
	longint      exp_cycle [$];

	`include "tb_fc_util.svh"

	fc_top uut (
		.clk        (clk),
		.rstn       (rstn),
		.weight     (weight),
		.weight_en  (weight_en),
		.in_valid   (in_valid),
		.din        (din),
		.out_valid  (out_valid),
		.dout       (dout),
		.out_neuron (out_neuron),
		.ready      (ready)
	);

	always #50 clk = ~clk;

	// reference model and output checker on pre-edge values
	always @(posedge clk)
	begin
		cycle++;
		if (!rstn)
		begin
			wcount   = 0;
			m_ready  = 0;
			m_step   = 0;
			m_neuron = 0;
			m_acc    = '0;
			exp_dout.delete();
			exp_neuron.delete();
			exp_cycle.delete();
		end
		else
		begin
			check_val("ready", ready, m_ready);
			if (out_valid)
			begin
				if (exp_dout.size() == 0)
				begin
					err_count++;
					$display("out_valid pulsed at %0t ns with no result pending", $time);
				end
				else
				begin
					check_val("dout", dout, exp_dout.pop_front());
					check_val("out_neuron", out_neuron, exp_neuron.pop_front());
					check_val("out_valid latency", cycle - exp_cycle.pop_front(), LATENCY);
				end
			end
			else if (exp_cycle.size() > 0 && cycle - exp_cycle[0] > LATENCY)
			begin
				err_count++;
				$display("out_valid missing for the group accepted at edge %0d", exp_cycle[0]);
				void'(exp_dout.pop_front());
				void'(exp_neuron.pop_front());
				void'(exp_cycle.pop_front());
			end
			if (in_valid && m_ready)
			begin
				m_acc = m_acc + beat_total(din, m_neuron, m_step);
				if (m_step == STEPS - 1)
				begin
					exp_dout.push_back(m_acc);
					exp_neuron.push_back(m_neuron);
					exp_cycle.push_back(cycle);
					m_acc    = '0;
					m_step   = 0;
					m_neuron = (m_neuron + 1) % NEURONS;
				end
				else
					m_step++;
			end
			if (weight_en && !m_ready)
			begin
				model_w[wcount] = weight;
				wcount++;
				m_ready = (wcount == TOTAL);
			end
		end
	end

	task automatic apply_reset();
		rstn <= 1'b0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
	endtask

	task automatic load_weights(input bit ones);
		logic [31:0] r;
		for (int k = 0; k < TOTAL; k++)
		begin
			r = rand_bits(1);
			@(posedge clk);
			weight_en <= 1'b1;
			weight    <= ones ? 1'b1 : r[0];
		end
		@(posedge clk);
		weight_en <= 1'b0;
	endtask

	// kind 0 small, 1 full range, 2 extremes only
	function automatic logic [LANES*DATA_W-1:0] beat_data(input int kind);
		logic [LANES*DATA_W-1:0] b;
		logic [31:0]             r;
		for (int l = 0; l < LANES; l++)
		begin
			if (kind == 0)
				r = rand_bits(16);
			else if (kind == 1)
				r = rand_bits(32);
			else
				r = rand_bits(1) ? 32'h7fff_ffff : 32'h8000_0000;
			b[l*DATA_W +: DATA_W] = r;
		end
		return b;
	endfunction

	task automatic send_groups(input int groups, input int kind, input bit gaps);
		int gap;
		for (int b = 0; b < groups * STEPS; b++)
		begin
			if (gaps)
			begin
				gap = rand_bits(2);
				for (int g = 0; g < gap; g++)
				begin
					@(posedge clk);
					in_valid <= 1'b0;
				end
			end
			@(posedge clk);
			in_valid <= 1'b1;
			din      <= beat_data(kind);
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_ready(input int limit);
		int n;
		n = 0;
		while (ready !== 1'b1 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (ready !== 1'b1)
		begin
			err_count++;
			$display("timeout: ready did not rise after the weight load");
		end
	endtask

	task automatic wait_results(input int limit);
		int n;
		n = 0;
		@(posedge clk);   // model has queued the last group by now
		while (exp_dout.size() > 0 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_dout.size() > 0)
		begin
			err_count++;
			$display("timeout: %0d results never appeared on out_valid", exp_dout.size());
		end
		repeat (3) @(posedge clk);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
		end
	endtask

	initial
	begin
		int errs;
		int pulses;
		rstn      = 1'b0;
		weight    = 1'b0;
		weight_en = 1'b0;
		in_valid  = 1'b0;
		din       = '0;

		errs = err_count;
		apply_reset();
		@(posedge clk);
		check_val("out_valid", out_valid, 0);
		check_val("ready", ready, 0);
		send_groups(1, 1, 0);   // store still empty
		pulses = 0;
		repeat (20)
		begin
			@(posedge clk);
			pulses += out_valid;
		end
		check_val("out_valid count", pulses, 0);
		load_weights(1);
		wait_ready(10);
		check_val("ready", ready, 1);
		end_test("early beats ignored", errs);

		errs = err_count;
		send_groups(4, 0, 0);
		wait_results(200);
		end_test("all ones weights", errs);

		errs = err_count;
		apply_reset();
		load_weights(0);
		wait_ready(10);
		send_groups(4, 1, 1);
		wait_results(200);
		end_test("random weights and gaps", errs);

		errs = err_count;
		send_groups(6, 1, 0);
		wait_results(200);
		end_test("back to back groups", errs);

		errs = err_count;
		send_groups(2, 0, 0);
		wait_results(50);
		end_test("fixed latency", errs);

		errs = err_count;
		send_groups(4, 2, 1);
		wait_results(200);
		end_test("extreme values", errs);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: weights/fc_weight_store.sv
`timescale 1ns/1ps

module fc_weight_store import fc_pkg::*; #(
	parameter int LANES   = DEF_LANES,
	parameter int STEPS   = DEF_STEPS,
	parameter int NEURONS = DEF_NEURONS,
	localparam int TOTAL  = LANES * STEPS * NEURONS,
	localparam int ADDR_W = $clog2(TOTAL + 1),
	localparam int STEP_W = (STEPS > 1) ? $clog2(STEPS) : 1,
	localparam int NEU_W  = (NEURONS > 1) ? $clog2(NEURONS) : 1
) (
	input  logic              clk,
	input  logic              rstn,
	input  logic              weight,
	input  logic              weight_en,
	input  logic [STEP_W-1:0] step_idx,
	input  logic [NEU_W-1:0]  neuron_idx,
	output logic              ready,
	output logic [LANES-1:0]  lane_w
);

	weight_state_e     state;
	logic [ADDR_W-1:0] waddr;   // stops at TOTAL
	logic [TOTAL-1:0]  w_bits;
	logic [ADDR_W-1:0] base;
	logic              wr_en;

	assign wr_en = weight_en && (state == w_loading);
	assign ready = (state == w_ready);

	// serial fill, one bit per enabled cycle
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state <= w_loading;
			waddr <= '0;
		end
		else if (wr_en)
		begin
			waddr <= waddr + 1'b1;
			if (waddr == ADDR_W'(TOTAL - 1))
				state <= w_ready;   // last bit lands on this edge
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			w_bits[waddr] <= weight;
	end

	// neuron block, then lane block, then step
	assign base = ADDR_W'(neuron_idx) * ADDR_W'(LANES * STEPS) + ADDR_W'(step_idx);

	always_comb
	begin
		for (int l = 0; l < LANES; l++)
			lane_w[l] = w_bits[base + ADDR_W'(l * STEPS)];
	end

endmodule
